/* axi_wr_pkg.sv */
`default_nettype none

package axi_wr_pkg;

	// **************************************************
	// bus widths
	// **************************************************
	localparam int ADDR_BITS  = 32;
	localparam int MID_BITS   = 4;  // id as issued by a master.
	localparam int SID_BITS   = 8;  // master index above the master id.
	localparam int LEN_BITS   = 4;
	localparam int SIZE_BITS  = 3;
	localparam int DATA_BITS  = 32;
	localparam int STRB_BITS  = DATA_BITS / 8;
	localparam int REGION_LSB = 16; // address bits above this pick the slave.

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [MID_BITS-1:0]  mid_t;
	typedef logic [SID_BITS-1:0]  sid_t;
	typedef logic [LEN_BITS-1:0]  len_t;
	typedef logic [SIZE_BITS-1:0] size_t;
	typedef logic [1:0]           burst_t;
	typedef logic [DATA_BITS-1:0] data_t;
	typedef logic [STRB_BITS-1:0] strb_t;
	typedef logic [1:0]           resp_t;

	// **************************************************
	// response codes
	// **************************************************
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

	// **************************************************
	// state and select encodings
	// **************************************************
	typedef enum logic [1:0] {
		SEL_S0,
		SEL_S1,
		SEL_DEF
	} slave_sel_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA
	} wr_state_e;

endpackage

`default_nettype wire

/* axi_aw_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface axi_aw_if import axi_wr_pkg::*; ();

	sid_t   awid;
	addr_t  awaddr;
	len_t   awlen;
	size_t  awsize;
	burst_t awburst;
	logic   awvalid;
	logic   awready;

	// arbiter side.
	modport src (
		output awid, awaddr, awlen, awsize, awburst, awvalid,
		input  awready
	);

	// slave side.
	modport dst (
		input  awid, awaddr, awlen, awsize, awburst, awvalid,
		output awready
	);

endinterface

`default_nettype wire

/* aw_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module aw_arbiter import axi_wr_pkg::*; (
	input  logic       ACLK,
	input  logic       ARESETn,
	input  mid_t       m0_id,
	input  addr_t      m0_addr,
	input  len_t       m0_len,
	input  size_t      m0_size,
	input  burst_t     m0_burst,
	input  logic       m0_valid,
	output logic       m0_ready,
	input  mid_t       m1_id,
	input  addr_t      m1_addr,
	input  len_t       m1_len,
	input  size_t      m1_size,
	input  burst_t     m1_burst,
	input  logic       m1_valid,
	output logic       m1_ready,
	input  logic       wr_done,
	axi_aw_if.src      aw,
	output logic       grant,
	output slave_sel_e sel,
	output logic       in_data
);

	wr_state_e state;
	wr_state_e state_nxt;
	logic      rr_ptr;
	logic      winner;
	logic      aw_hs;
	addr_t     addr_q;

	// **************************************************
	// round-robin pick and address decode
	// **************************************************
	always_comb begin
		if (m0_valid && m1_valid)
			winner = rr_ptr; // both asking, pointer decides.
		else
			winner = m1_valid;
	end

	always_comb begin
		if (addr_q[ADDR_BITS-1:REGION_LSB] == '0)
			sel = SEL_S0;
		else if (addr_q[ADDR_BITS-1:REGION_LSB] == (ADDR_BITS-REGION_LSB)'(1))
			sel = SEL_S1;
		else
			sel = SEL_DEF; // unmapped region.
	end

	// **************************************************
	// grant state machine
	// **************************************************
	always_comb begin
		case (state)
			ST_IDLE: state_nxt = (m0_valid || m1_valid) ? ST_ADDR : ST_IDLE;
			ST_ADDR: state_nxt = aw_hs ? ST_DATA : ST_ADDR;
			ST_DATA: state_nxt = wr_done ? ST_IDLE : ST_DATA;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state  <= ST_IDLE;
			grant  <= 1'b0;
			rr_ptr <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == ST_IDLE && (m0_valid || m1_valid)) begin
				grant  <= winner;
				rr_ptr <= ~winner; // favour the loser next time.
			end
		end
	end

	always_ff @(posedge ACLK) begin
		if (state == ST_IDLE)
			addr_q <= winner ? m1_addr : m0_addr;
	end

	// **************************************************
	// forwarded address channel
	// **************************************************
	assign aw.awid    = {(SID_BITS-MID_BITS)'(grant), grant ? m1_id : m0_id};
	assign aw.awaddr  = addr_q;
	assign aw.awlen   = grant ? m1_len : m0_len;
	assign aw.awsize  = grant ? m1_size : m0_size;
	assign aw.awburst = grant ? m1_burst : m0_burst;
	assign aw.awvalid = (state == ST_ADDR) && (grant ? m1_valid : m0_valid);

	assign aw_hs    = aw.awvalid && aw.awready;
	assign m0_ready = (state == ST_ADDR) && !grant && aw.awready;
	assign m1_ready = (state == ST_ADDR) && grant && aw.awready;
	assign in_data  = (state == ST_DATA);

endmodule

`default_nettype wire

/* w_data_router.sv */
`timescale 1ns/100ps
`default_nettype none

module w_data_router import axi_wr_pkg::*; (
	input  logic       ACLK,
	input  logic       ARESETn,
	input  data_t      m0_wdata,
	input  strb_t      m0_wstrb,
	input  logic       m0_wlast,
	input  logic       m0_wvalid,
	input  data_t      m1_wdata,
	input  strb_t      m1_wstrb,
	input  logic       m1_wlast,
	input  logic       m1_wvalid,
	output logic       m0_wready,
	output logic       m1_wready,
	input  logic       grant,
	input  slave_sel_e sel,
	input  logic       in_data,
	output data_t      s0_wdata,
	output strb_t      s0_wstrb,
	output logic       s0_wlast,
	output logic       s0_wvalid,
	output data_t      s1_wdata,
	output strb_t      s1_wstrb,
	output logic       s1_wlast,
	output logic       s1_wvalid,
	output data_t      def_wdata,
	output strb_t      def_wstrb,
	output logic       def_wlast,
	output logic       def_wvalid,
	input  logic       s0_wready,
	input  logic       s1_wready,
	input  logic       def_wready,
	output logic       wr_done
);

	data_t wdata;
	strb_t wstrb;
	logic  wlast;
	logic  wvalid;
	logic  wready;
	logic  beat_hs;
	len_t  beat_cnt;

	// granted master's beat.
	assign wdata  = grant ? m1_wdata : m0_wdata;
	assign wstrb  = grant ? m1_wstrb : m0_wstrb;
	assign wlast  = grant ? m1_wlast : m0_wlast;
	assign wvalid = in_data && (grant ? m1_wvalid : m0_wvalid);

	always_comb begin
		case (sel)
			SEL_S0:  wready = s0_wready;
			SEL_S1:  wready = s1_wready;
			default: wready = def_wready;
		endcase
	end

	assign beat_hs   = wvalid && wready;
	assign m0_wready = in_data && !grant && wready;
	assign m1_wready = in_data && grant && wready;

	// payload goes everywhere, valid only to the target.
	assign s0_wdata   = wdata;
	assign s0_wstrb   = wstrb;
	assign s0_wlast   = wlast;
	assign s0_wvalid  = wvalid && (sel == SEL_S0);
	assign s1_wdata   = wdata;
	assign s1_wstrb   = wstrb;
	assign s1_wlast   = wlast;
	assign s1_wvalid  = wvalid && (sel == SEL_S1);
	assign def_wdata  = wdata;
	assign def_wstrb  = wstrb;
	assign def_wlast  = wlast;
	assign def_wvalid = wvalid && (sel == SEL_DEF);

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn)
			beat_cnt <= '0;
		else if (!in_data)
			beat_cnt <= '0; // cleared between grants.
		else if (beat_hs)
			beat_cnt <= beat_cnt + 1'b1;
	end

	// a burst never runs past sixteen beats, even without wlast.
	assign wr_done = beat_hs && (wlast || beat_cnt == '1);

endmodule

`default_nettype wire

/* b_resp_router.sv */
`timescale 1ns/100ps
`default_nettype none

module b_resp_router import axi_wr_pkg::*; (
	input  logic  ACLK,
	input  logic  ARESETn,
	input  sid_t  s0_bid,
	input  resp_t s0_bresp,
	input  logic  s0_bvalid,
	output logic  s0_bready,
	input  sid_t  s1_bid,
	input  resp_t s1_bresp,
	input  logic  s1_bvalid,
	output logic  s1_bready,
	input  sid_t  def_bid,
	input  resp_t def_bresp,
	input  logic  def_bvalid,
	output logic  def_bready,
	output mid_t  m0_bid,
	output resp_t m0_bresp,
	output logic  m0_bvalid,
	input  logic  m0_bready,
	output mid_t  m1_bid,
	output resp_t m1_bresp,
	output logic  m1_bvalid,
	input  logic  m1_bready
);

	slave_sel_e cur;
	slave_sel_e lock_src;
	logic       locked;
	sid_t       bid;
	resp_t      bresp;
	logic       bvalid;
	logic       bready;
	logic       to_m1;

	// fixed priority while free.
	always_comb begin
		if (locked)
			cur = lock_src;
		else if (s0_bvalid)
			cur = SEL_S0;
		else if (s1_bvalid)
			cur = SEL_S1;
		else
			cur = SEL_DEF;
	end

	always_comb begin
		case (cur)
			SEL_S0: begin
				bid    = s0_bid;
				bresp  = s0_bresp;
				bvalid = s0_bvalid;
			end
			SEL_S1: begin
				bid    = s1_bid;
				bresp  = s1_bresp;
				bvalid = s1_bvalid;
			end
			default: begin
				bid    = def_bid;
				bresp  = def_bresp;
				bvalid = def_bvalid;
			end
		endcase
	end

	assign to_m1 = (bid[SID_BITS-1:MID_BITS] != '0); // master index.

	assign m0_bid    = bid[MID_BITS-1:0];
	assign m0_bresp  = bresp;
	assign m0_bvalid = bvalid && !to_m1;
	assign m1_bid    = bid[MID_BITS-1:0];
	assign m1_bresp  = bresp;
	assign m1_bvalid = bvalid && to_m1;

	assign bready     = to_m1 ? m1_bready : m0_bready;
	assign s0_bready  = (cur == SEL_S0) && bready;
	assign s1_bready  = (cur == SEL_S1) && bready;
	assign def_bready = (cur == SEL_DEF) && bready;

	// hold the chosen source until its response is taken.
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			locked   <= 1'b0;
			lock_src <= SEL_S0;
		end else begin
			locked   <= bvalid && !bready;
			lock_src <= cur;
		end
	end

endmodule

`default_nettype wire

/* default_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module default_slave import axi_wr_pkg::*; (
	input  logic  ACLK,
	input  logic  ARESETn,
	axi_aw_if.dst aw,
	input  logic  wlast,
	input  logic  wvalid,
	output logic  wready,
	output sid_t  bid,
	output resp_t bresp,
	output logic  bvalid,
	input  logic  bready
);

	typedef enum logic [1:0] {
		DS_IDLE,
		DS_DATA,
		DS_RESP
	} ds_state_e;

	ds_state_e state;
	ds_state_e state_nxt;
	sid_t      id_q;

	always_comb begin
		case (state)
			DS_IDLE: state_nxt = (aw.awvalid && aw.awready) ? DS_DATA : DS_IDLE;
			DS_DATA: state_nxt = (wvalid && wready && wlast) ? DS_RESP : DS_DATA;
			DS_RESP: state_nxt = bready ? DS_IDLE : DS_RESP;
			default: state_nxt = DS_IDLE;
		endcase
	end

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn)
			state <= DS_IDLE;
		else
			state <= state_nxt;
	end

	always_ff @(posedge ACLK) begin
		if (aw.awvalid && aw.awready)
			id_q <= aw.awid; // echoed back in the response.
	end

	assign aw.awready = (state == DS_IDLE);
	assign wready     = (state == DS_DATA); // data is dropped.
	assign bvalid     = (state == DS_RESP);
	assign bid        = id_q;
	assign bresp      = RESP_DECERR;

endmodule

`default_nettype wire

/* axi_wr_interconnect.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_wr_interconnect import axi_wr_pkg::*; (
	input  logic   ACLK,
	input  logic   ARESETn,
	// **************************************************
	// master 0
	// **************************************************
	input  mid_t   m0_awid,
	input  addr_t  m0_awaddr,
	input  len_t   m0_awlen,
	input  size_t  m0_awsize,
	input  burst_t m0_awburst,
	input  logic   m0_awvalid,
	output logic   m0_awready,
	input  data_t  m0_wdata,
	input  strb_t  m0_wstrb,
	input  logic   m0_wlast,
	input  logic   m0_wvalid,
	output logic   m0_wready,
	output mid_t   m0_bid,
	output resp_t  m0_bresp,
	output logic   m0_bvalid,
	input  logic   m0_bready,
	// **************************************************
	// master 1
	// **************************************************
	input  mid_t   m1_awid,
	input  addr_t  m1_awaddr,
	input  len_t   m1_awlen,
	input  size_t  m1_awsize,
	input  burst_t m1_awburst,
	input  logic   m1_awvalid,
	output logic   m1_awready,
	input  data_t  m1_wdata,
	input  strb_t  m1_wstrb,
	input  logic   m1_wlast,
	input  logic   m1_wvalid,
	output logic   m1_wready,
	output mid_t   m1_bid,
	output resp_t  m1_bresp,
	output logic   m1_bvalid,
	input  logic   m1_bready,
	// **************************************************
	// slave 0
	// **************************************************
	output sid_t   s0_awid,
	output addr_t  s0_awaddr,
	output len_t   s0_awlen,
	output size_t  s0_awsize,
	output burst_t s0_awburst,
	output logic   s0_awvalid,
	input  logic   s0_awready,
	output data_t  s0_wdata,
	output strb_t  s0_wstrb,
	output logic   s0_wlast,
	output logic   s0_wvalid,
	input  logic   s0_wready,
	input  sid_t   s0_bid,
	input  resp_t  s0_bresp,
	input  logic   s0_bvalid,
	output logic   s0_bready,
	// **************************************************
	// slave 1
	// **************************************************
	output sid_t   s1_awid,
	output addr_t  s1_awaddr,
	output len_t   s1_awlen,
	output size_t  s1_awsize,
	output burst_t s1_awburst,
	output logic   s1_awvalid,
	input  logic   s1_awready,
	output data_t  s1_wdata,
	output strb_t  s1_wstrb,
	output logic   s1_wlast,
	output logic   s1_wvalid,
	input  logic   s1_wready,
	input  sid_t   s1_bid,
	input  resp_t  s1_bresp,
	input  logic   s1_bvalid,
	output logic   s1_bready
);

	logic       grant;
	slave_sel_e sel;
	logic       in_data;
	logic       wr_done;
	logic       def_wlast;
	logic       def_wvalid;
	logic       def_wready;
	sid_t       def_bid;
	resp_t      def_bresp;
	logic       def_bvalid;
	logic       def_bready;

	axi_aw_if aw_bus ();
	axi_aw_if aw_def (); // default target's view of the address channel.

	aw_arbiter u_aw_arbiter (
		.ACLK     (ACLK),
		.ARESETn  (ARESETn),
		.m0_id    (m0_awid),
		.m0_addr  (m0_awaddr),
		.m0_len   (m0_awlen),
		.m0_size  (m0_awsize),
		.m0_burst (m0_awburst),
		.m0_valid (m0_awvalid),
		.m0_ready (m0_awready),
		.m1_id    (m1_awid),
		.m1_addr  (m1_awaddr),
		.m1_len   (m1_awlen),
		.m1_size  (m1_awsize),
		.m1_burst (m1_awburst),
		.m1_valid (m1_awvalid),
		.m1_ready (m1_awready),
		.wr_done  (wr_done),
		.aw       (aw_bus.src),
		.grant    (grant),
		.sel      (sel),
		.in_data  (in_data)
	);

	// **************************************************
	// address fan-out by decoded target
	// **************************************************
	assign s0_awid    = aw_bus.awid;
	assign s0_awaddr  = aw_bus.awaddr;
	assign s0_awlen   = aw_bus.awlen;
	assign s0_awsize  = aw_bus.awsize;
	assign s0_awburst = aw_bus.awburst;
	assign s0_awvalid = aw_bus.awvalid && (sel == SEL_S0);

	assign s1_awid    = aw_bus.awid;
	assign s1_awaddr  = aw_bus.awaddr;
	assign s1_awlen   = aw_bus.awlen;
	assign s1_awsize  = aw_bus.awsize;
	assign s1_awburst = aw_bus.awburst;
	assign s1_awvalid = aw_bus.awvalid && (sel == SEL_S1);

	assign aw_def.awid    = aw_bus.awid;
	assign aw_def.awaddr  = aw_bus.awaddr;
	assign aw_def.awlen   = aw_bus.awlen;
	assign aw_def.awsize  = aw_bus.awsize;
	assign aw_def.awburst = aw_bus.awburst;
	assign aw_def.awvalid = aw_bus.awvalid && (sel == SEL_DEF);

	always_comb begin
		case (sel)
			SEL_S0:  aw_bus.awready = s0_awready;
			SEL_S1:  aw_bus.awready = s1_awready;
			default: aw_bus.awready = aw_def.awready;
		endcase
	end

	w_data_router u_w_data_router (
		.def_wdata (),
		.def_wstrb (),
		.*
	);

	b_resp_router u_b_resp_router (.*);

	default_slave u_default_slave (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.aw      (aw_def.dst),
		.wlast   (def_wlast),
		.wvalid  (def_wvalid),
		.wready  (def_wready),
		.bid     (def_bid),
		.bresp   (def_bresp),
		.bvalid  (def_bvalid),
		.bready  (def_bready)
	);

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_checker import axi_wr_pkg::*; (
	input  logic   ACLK,
	input  logic   ARESETn,
	input  logic   rr_mode,
	input  logic   m0_awvalid, m1_awvalid,
	input  sid_t   s0_awid, s1_awid,
	input  addr_t  s0_awaddr, s1_awaddr,
	input  len_t   s0_awlen, s1_awlen,
	input  size_t  s0_awsize, s1_awsize,
	input  burst_t s0_awburst, s1_awburst,
	input  logic   s0_awvalid, s0_awready, s1_awvalid, s1_awready,
	input  data_t  s0_wdata, s1_wdata,
	input  strb_t  s0_wstrb, s1_wstrb,
	input  logic   s0_wlast, s0_wvalid, s0_wready, s1_wlast, s1_wvalid, s1_wready,
	input  logic   s0_bvalid, s1_bvalid,
	input  mid_t   m0_bid, m1_bid,
	input  resp_t  m0_bresp, m1_bresp,
	input  logic   m0_bvalid, m0_bready, m1_bvalid, m1_bready
);

	logic [48:0] aw_q [2][$]; // {id, addr, len, size, burst} per slave.
	logic [36:0] w_q [2][$];  // {data, strb, last} per master.
	logic [5:0]  b_q [2][$];  // {id, resp} per master.
	int err_aw = 0;
	int err_w = 0;
	int err_b = 0;
	int err_misc = 0;
	bit seen_req = 1'b0;
	bit active = 1'b0;
	bit other_wait = 1'b0;
	int cur_mi = 0;
	int cur_s = 0;
	int last_mi = -1;

	task expect_aw(input int s, input logic [48:0] rec);
		aw_q[s].push_back(rec);
	endtask

	task expect_w(input int mi, input logic [36:0] rec);
		w_q[mi].push_back(rec);
	endtask

	task expect_b(input int mi, input logic [5:0] rec);
		b_q[mi].push_back(rec);
	endtask

	// **************************************************
	// per-channel comparisons
	// **************************************************
	task check_aw(input int s, input sid_t id, input addr_t a, input len_t l,
			input size_t sz, input burst_t bu);
		int  i;
		bit  found;
		found = 1'b0;
		for (i = 0; i < aw_q[s].size(); i++) begin
			if (aw_q[s][i][48:41] == id) begin
				found = 1'b1;
				if (aw_q[s][i] != {id, a, l, sz, bu}) begin
					err_aw++;
					$display("Error %0t: slave %0d AW expected %h got %h", $time, s,
						aw_q[s][i], {id, a, l, sz, bu});
				end
				aw_q[s].delete(i);
				break;
			end
		end
		if (!found) begin
			err_aw++;
			$display("Error %0t: unexpected AW with id %h at slave %0d", $time, id, s);
		end
		cur_mi = int'(id[7:4]);
		cur_s = s;
		active = 1'b1;
		if (rr_mode && other_wait && last_mi == cur_mi) begin
			err_misc++;
			$display("Error %0t: master %0d granted twice in a row while the other waited",
				$time, cur_mi);
		end
		other_wait = 1'b0;
		last_mi = rr_mode ? cur_mi : -1;
	endtask

	task check_w(input int s, input data_t d, input strb_t st, input logic last);
		logic [36:0] e;
		if (!active || s != cur_s || w_q[cur_mi].size() == 0) begin
			err_misc++;
			$display("Error %0t: W beat at slave %0d outside a burst", $time, s);
		end else begin
			e = w_q[cur_mi].pop_front();
			if (e != {d, st, last}) begin
				err_w++;
				$display("Error %0t: slave %0d W expected %h got %h", $time, s, e, {d, st, last});
			end
			if (last) begin
				active = 1'b0;
				other_wait = (cur_mi == 0) ? m1_awvalid : m0_awvalid; // loser still asking.
			end
		end
	endtask

	task check_b(input int mi, input mid_t id, input resp_t resp);
		logic [5:0] e;
		if (b_q[mi].size() == 0) begin
			err_misc++;
			$display("Error %0t: unexpected B at master %0d", $time, mi);
		end else begin
			e = b_q[mi].pop_front();
			if (e != {id, resp}) begin
				err_b++;
				$display("Error %0t: master %0d B expected %h got %h", $time, mi, e, {id, resp});
			end
		end
	endtask

	task finish_check();
		int n;
		n = aw_q[0].size() + aw_q[1].size() + w_q[0].size() + w_q[1].size();
		n = n + b_q[0].size() + b_q[1].size();
		if (n != 0) begin
			err_misc += n;
			$display("%0d expected transfers never arrived", n);
		end
	endtask

	always @(posedge ACLK) begin
		if (!seen_req && (s0_awvalid || s1_awvalid || s0_wvalid || s1_wvalid ||
				s0_bvalid || s1_bvalid || m0_bvalid || m1_bvalid)) begin
			err_misc++;
			$display("Error %0t: valid seen before any request", $time);
		end
		if (m0_awvalid || m1_awvalid)
			seen_req = 1'b1;
		if ((s0_awvalid || s1_awvalid) && active) begin
			err_misc++;
			$display("Error %0t: AW while a burst is open", $time);
		end
		if (s0_awvalid && s0_awready)
			check_aw(0, s0_awid, s0_awaddr, s0_awlen, s0_awsize, s0_awburst);
		if (s1_awvalid && s1_awready)
			check_aw(1, s1_awid, s1_awaddr, s1_awlen, s1_awsize, s1_awburst);
		if (s0_wvalid && s0_wready)
			check_w(0, s0_wdata, s0_wstrb, s0_wlast);
		if (s1_wvalid && s1_wready)
			check_w(1, s1_wdata, s1_wstrb, s1_wlast);
		if (m0_bvalid && m0_bready)
			check_b(0, m0_bid, m0_bresp);
		if (m1_bvalid && m1_bready)
			check_b(1, m1_bid, m1_bresp);
	end

endmodule

`default_nettype wire

/* tb_axi_wr_interconnect.sv */
`timescale 1ns/100ps
`default_nettype none

// accepts AW and W with random ready and answers OKAY.
module slave_model import axi_wr_pkg::*; (
	input  logic       ACLK,
	input  logic       ARESETn,
	input  logic [2:0] rdy,
	input  sid_t       awid,
	input  logic       awvalid,
	output logic       awready,
	input  logic       wvalid,
	input  logic       wlast,
	output logic       wready,
	output sid_t       bid,
	output resp_t      bresp,
	output logic       bvalid,
	input  logic       bready
);

	sid_t       aw_q[$];
	sid_t       b_q[$];
	logic [2:0] r;

	always @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			awready = 1'b0;
			wready = 1'b0;
			bvalid = 1'b0;
			bid = '0;
			bresp = RESP_OKAY;
			aw_q.delete();
			b_q.delete();
		end else begin
			r = rdy;
			if (awvalid && awready)
				aw_q.push_back(awid);
			if (wvalid && wready && wlast && aw_q.size() > 0)
				b_q.push_back(aw_q.pop_front());
			if (bvalid && bready)
				void'(b_q.pop_front());
			#1;
			awready = r[0];
			wready = r[1];
			bvalid = (b_q.size() > 0) && (bvalid || r[2]); // held once raised.
			if (b_q.size() > 0)
				bid = b_q[0];
		end
	end

endmodule

module tb_axi_wr_interconnect import axi_wr_pkg::*; ();

	localparam int TIMEOUT = 2000;

	logic   ACLK;
	logic   ARESETn;
	mid_t   m0_awid, m1_awid, m0_bid, m1_bid;
	addr_t  m0_awaddr, m1_awaddr, s0_awaddr, s1_awaddr;
	len_t   m0_awlen, m1_awlen, s0_awlen, s1_awlen;
	size_t  m0_awsize, m1_awsize, s0_awsize, s1_awsize;
	burst_t m0_awburst, m1_awburst, s0_awburst, s1_awburst;
	data_t  m0_wdata, m1_wdata, s0_wdata, s1_wdata;
	strb_t  m0_wstrb, m1_wstrb, s0_wstrb, s1_wstrb;
	sid_t   s0_awid, s1_awid, s0_bid, s1_bid;
	resp_t  m0_bresp, m1_bresp, s0_bresp, s1_bresp;
	logic   m0_awvalid, m0_awready, m0_wlast, m0_wvalid, m0_wready, m0_bvalid, m0_bready;
	logic   m1_awvalid, m1_awready, m1_wlast, m1_wvalid, m1_wready, m1_bvalid, m1_bready;
	logic   s0_awvalid, s0_awready, s0_wlast, s0_wvalid, s0_wready, s0_bvalid, s0_bready;
	logic   s1_awvalid, s1_awready, s1_wlast, s1_wvalid, s1_wready, s1_bvalid, s1_bready;
	logic [31:0] rng;
	logic [2:0]  rdy0, rdy1;
	logic   rr_mode;
	bit     hung;
	mid_t   id_cnt [2];

	assign m0_awsize = 3'd2; // full-width incrementing beats.
	assign m1_awsize = 3'd1; // half-width fixed beats.
	assign m0_awburst = 2'b01;
	assign m1_awburst = 2'b00;

	axi_wr_interconnect dut (.*);
	tb_checker chk (.*);

	slave_model u_s0 (.ACLK, .ARESETn, .rdy(rdy0), .awid(s0_awid), .awvalid(s0_awvalid),
		.awready(s0_awready), .wvalid(s0_wvalid), .wlast(s0_wlast), .wready(s0_wready),
		.bid(s0_bid), .bresp(s0_bresp), .bvalid(s0_bvalid), .bready(s0_bready));
	slave_model u_s1 (.ACLK, .ARESETn, .rdy(rdy1), .awid(s1_awid), .awvalid(s1_awvalid),
		.awready(s1_awready), .wvalid(s1_wvalid), .wlast(s1_wlast), .wready(s1_wready),
		.bid(s1_bid), .bresp(s1_bresp), .bvalid(s1_bvalid), .bready(s1_bready));

	initial begin
		ACLK = 1'b0;
		forever #4 ACLK = ~ACLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	always @(negedge ACLK) begin
		rng = xorshift(rng);
		rdy0 = rng[2:0];
		rdy1 = rng[5:3];
	end

	task automatic get_rand(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	// **************************************************
	// reference model of the decode
	// **************************************************
	function automatic int exp_slave(input addr_t a);
		if (a[31:16] == 16'h0000)
			return 0;
		if (a[31:16] == 16'h0001)
			return 1;
		return 2; // default slave.
	endfunction

	function automatic resp_t exp_resp(input addr_t a);
		return (exp_slave(a) == 2) ? RESP_DECERR : RESP_OKAY;
	endfunction

	// **************************************************
	// master drivers
	// **************************************************
	task automatic set_aw(input int mi, input logic v, input mid_t id, input addr_t a,
			input len_t l);
		if (mi == 0) begin
			m0_awvalid = v;
			m0_awid = id;
			m0_awaddr = a;
			m0_awlen = l;
		end else begin
			m1_awvalid = v;
			m1_awid = id;
			m1_awaddr = a;
			m1_awlen = l;
		end
	endtask

	task automatic set_w(input int mi, input logic v, input data_t d, input strb_t st,
			input logic last);
		if (mi == 0) begin
			m0_wvalid = v;
			m0_wdata = d;
			m0_wstrb = st;
			m0_wlast = last;
		end else begin
			m1_wvalid = v;
			m1_wdata = d;
			m1_wstrb = st;
			m1_wlast = last;
		end
	endtask

	task automatic set_bready(input int mi, input logic v);
		if (mi == 0)
			m0_bready = v;
		else
			m1_bready = v;
	endtask

	task automatic wait_ready(input int mi, input int ch, input string what, output bit ok);
		int t;
		bit r;
		ok = 1'b0;
		for (t = 0; t < TIMEOUT; t++) begin
			@(posedge ACLK);
			case (ch)
				0:       r = (mi == 0) ? m0_awready : m1_awready;
				1:       r = (mi == 0) ? m0_wready : m1_wready;
				default: r = (mi == 0) ? m0_bvalid : m1_bvalid;
			endcase
			if (r) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			$display("timeout: master %0d never saw %s", mi, what);
			hung = 1'b1;
		end
	endtask

	task automatic write_burst(input int mi, input addr_t addr, input len_t len);
		mid_t        id;
		sid_t        sid;
		size_t       sz;
		burst_t      bu;
		logic [31:0] r;
		bit          ok;
		int          b;
		id = id_cnt[mi];
		id_cnt[mi] = id + 4'd1;
		sid = {4'(mi), id};
		sz = (mi == 0) ? 3'd2 : 3'd1;
		bu = (mi == 0) ? 2'b01 : 2'b00;
		if (exp_slave(addr) != 2)
			chk.expect_aw(exp_slave(addr), {sid, addr, len, sz, bu});
		chk.expect_b(mi, {id, exp_resp(addr)});
		@(posedge ACLK);
		#1;
		set_aw(mi, 1'b1, id, addr, len);
		wait_ready(mi, 0, "AWREADY", ok);
		#1;
		set_aw(mi, 1'b0, '0, '0, '0);
		if (!ok)
			return;
		for (b = 0; b <= int'(len); b++) begin
			get_rand(r);
			if (exp_slave(addr) != 2)
				chk.expect_w(mi, {r, r[7:4], b == int'(len)});
			set_w(mi, 1'b1, r, r[7:4], b == int'(len));
			wait_ready(mi, 1, "WREADY", ok);
			#1;
			set_w(mi, 1'b0, '0, '0, 1'b0);
			if (!ok)
				return;
		end
		set_bready(mi, 1'b1);
		wait_ready(mi, 2, "BVALID", ok);
		#1;
		set_bready(mi, 1'b0);
	endtask

	task automatic run_random(input int mi, input int n, input bit any_region);
		logic [31:0] r;
		logic [15:0] region;
		int          i;
		for (i = 0; i < n && !hung; i++) begin
			get_rand(r);
			region = r[31] ? 16'h0001 : 16'h0000;
			if (any_region && r[30:29] == 2'b11)
				region = {4'h8, r[27:16]}; // unmapped.
			write_burst(mi, {region, r[15:2], 2'b00}, r[20:17]);
		end
	endtask

	initial begin
		int errs;
		rng = 32'd78;
		hung = 1'b0;
		rr_mode = 1'b0;
		id_cnt[0] = '0;
		id_cnt[1] = '0;
		ARESETn = 1'b0;
		for (int mi = 0; mi < 2; mi++) begin
			set_aw(mi, 1'b0, '0, '0, '0);
			set_w(mi, 1'b0, '0, '0, 1'b0);
			set_bready(mi, 1'b0);
		end
		repeat (16) @(posedge ACLK);
		#1;
		ARESETn = 1'b1;
		repeat (4) @(posedge ACLK);
		write_burst(0, 32'h0000_0100, 4'd3);
		write_burst(0, 32'h0001_0040, 4'd0);
		write_burst(0, 32'h0002_0000, 4'd1);
		write_burst(1, 32'h0001_0200, 4'd7);
		write_burst(1, 32'hff00_0010, 4'd2);
		rr_mode = 1'b1;
		fork
			run_random(0, 8, 1'b0);
			run_random(1, 8, 1'b0);
		join
		rr_mode = 1'b0;
		fork
			run_random(0, 12, 1'b1);
			run_random(1, 12, 1'b1);
		join
		repeat (20) @(posedge ACLK);
		chk.finish_check();
		errs = chk.err_aw + chk.err_w + chk.err_b + chk.err_misc;
		$display("errors: aw %0d, w %0d, b %0d, other %0d, timeouts %0d", chk.err_aw,
			chk.err_w, chk.err_b, chk.err_misc, int'(hung));
		if (errs == 0 && !hung)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
axi_wr_pkg.sv
axi_aw_if.sv
aw_arbiter.sv
w_data_router.sv
b_resp_router.sv
default_slave.sv
axi_wr_interconnect.sv
tb_checker.sv
tb_axi_wr_interconnect.sv

/* run_sim.sh */
#!/bin/sh
# builds with Verilator, runs, and decides the verdict from sim.log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_axi_wr_interconnect \
	-f filelist.f -o sim_tb > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "Simulation PASSED" sim.log && echo "run passed" \
	|| { echo "run failed, see sim.log"; exit 1; }
